// File: include/climate_cfg_consts.svh
`ifndef CLIMATE_CFG_CONSTS_SVH
`define CLIMATE_CFG_CONSTS_SVH

// Clock cycles per serial bit
`define CFG_BIT_CYCLES 16

// Data bits carried by one serial frame
`define CFG_DATA_BITS 8

// Words in one configuration sequence (four thresholds and the humidity limit)
`define CFG_WORD_COUNT 5

`endif

// File: hdl/climate_cfg_pkg.sv
`default_nettype none

`include "climate_cfg_consts.svh"

package climate_cfg_pkg;

  // Codes 0 to 7 are visible on db_state
  typedef enum logic [2:0] {
    idle          = 3'd0,
    recv_temp1    = 3'd1,
    recv_temp2    = 3'd2,
    recv_temp3    = 3'd3,
    recv_temp4    = 3'd4,
    recv_humidity = 3'd5,
    error         = 3'd6,
    done          = 3'd7
  } cfg_state_t;

  typedef struct packed {
    logic [`CFG_DATA_BITS-1:0] data;
    logic                      word_ok; // Parity and stop bit both good
  } rx_word_t;

  typedef struct packed {
    logic temp1;
    logic temp2;
    logic temp3;
    logic temp4;
    logic humidity;
  } cfg_load_t;

  typedef struct packed {
    logic [`CFG_DATA_BITS-1:0] temp1;
    logic [`CFG_DATA_BITS-1:0] temp2;
    logic [`CFG_DATA_BITS-1:0] temp3;
    logic [`CFG_DATA_BITS-1:0] temp4;
    logic [`CFG_DATA_BITS-1:0] humidity_limit;
  } climate_limits_t;

endpackage

`default_nettype wire

// File: hdl/cfg_bit_timer.sv
`timescale 1ns/1ps
`default_nettype none

`include "climate_cfg_consts.svh"

module cfg_bit_timer (
  input  logic       clock,
  input  logic       reset,
  input  logic       run,
  output logic       sample_tick,
  output logic [3:0] bit_index,
  output logic       frame_end
);

  localparam int unsigned cnt_w = $clog2(`CFG_BIT_CYCLES);

  logic [cnt_w-1:0] cycle_cnt;
  logic [cnt_w-1:0] cycle_last;

  // The start bit lands the tick half a bit after the edge was seen
  assign cycle_last = (bit_index == 4'd0) ? cnt_w'(`CFG_BIT_CYCLES / 2 - 2)
                                          : cnt_w'(`CFG_BIT_CYCLES - 1);

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      cycle_cnt   <= '0;
      bit_index   <= 4'd0;
      sample_tick <= 1'b0;
    end else if (!run) begin
      cycle_cnt   <= '0;
      bit_index   <= 4'd0;
      sample_tick <= 1'b0;
    end else begin
      sample_tick <= (cycle_cnt == cycle_last);
      if (cycle_cnt == cycle_last)
        cycle_cnt <= '0;
      else
        cycle_cnt <= cycle_cnt + 1'b1;
      if (sample_tick)
        bit_index <= bit_index + 1'b1; // Index names the bit sampled by the current tick
    end
  end

  // Start, data, parity, then stop at index 10
  assign frame_end = sample_tick && (bit_index == 4'(`CFG_DATA_BITS + 2));

  // The receiver must drop run only after the tick it reacted to
  assert property (@(posedge clock) disable iff (reset) sample_tick |-> run);

endmodule

`default_nettype wire

// File: hdl/cfg_serial_rx.sv
`timescale 1ns/1ps
`default_nettype none

`include "climate_cfg_consts.svh"

module cfg_serial_rx import climate_cfg_pkg::*; (
  input  logic       clock,
  input  logic       reset,
  input  logic       serial_in,
  input  logic       sample_tick,
  input  logic [3:0] bit_index,
  input  logic       frame_end,
  output logic       timer_run,
  output rx_word_t   rx_word,
  output logic       rx_valid
);

  logic [1:0]                sync_q;
  logic                      line_q;
  logic                      line;
  logic                      start_edge;
  logic [`CFG_DATA_BITS-1:0] shift_q;
  logic                      parity_q;
  logic                      data_bit;
  logic                      parity_bit;

  assign line = sync_q[1];

  // The line idles high, so reset loads ones to avoid a false start
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      sync_q <= 2'b11;
      line_q <= 1'b1;
    end else begin
      sync_q <= {sync_q[0], serial_in};
      line_q <= line;
    end
  end

  assign start_edge = !timer_run && line_q && !line;

  assign data_bit   = (bit_index >= 4'd1) && (bit_index <= 4'(`CFG_DATA_BITS));
  assign parity_bit = (bit_index == 4'(`CFG_DATA_BITS + 1));

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      timer_run <= 1'b0;
      rx_valid  <= 1'b0;
    end else begin
      rx_valid <= 1'b0;
      if (start_edge) begin
        timer_run <= 1'b1;
      end else if (sample_tick) begin
        if (bit_index == 4'd0 && line)
          timer_run <= 1'b0; // The start bit did not hold to mid-bit
        if (frame_end) begin
          timer_run <= 1'b0;
          rx_valid  <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    if (start_edge) begin
      parity_q <= 1'b0;
    end else if (sample_tick && (data_bit || parity_bit)) begin
      parity_q <= parity_q ^ line; // Even parity leaves this at zero
      if (data_bit)
        shift_q <= {line, shift_q[`CFG_DATA_BITS-1:1]}; // LSB arrives first
    end
    if (frame_end) begin
      rx_word.data    <= shift_q;
      rx_word.word_ok <= !parity_q && line;
    end
  end

  // Frames are at least eleven bits long, so words never come back to back
  assert property (@(posedge clock) disable iff (reset) rx_valid |=> !rx_valid);

endmodule

`default_nettype wire

// File: hdl/config_manager_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module config_manager_ctrl import climate_cfg_pkg::*; (
  input  logic       clock,
  input  logic       reset,
  input  logic       config_request,
  input  rx_word_t   rx_word,
  input  logic       rx_valid,
  output cfg_load_t  load,
  output logic       commit,
  output logic       config_done,
  output logic       config_error,
  output cfg_state_t db_state
);

  cfg_state_t state;
  cfg_state_t state_next;

  always_ff @(posedge clock or posedge reset) begin
    if (reset)
      state <= idle;
    else
      state <= state_next;
  end

  always_comb begin
    state_next = state;
    if (config_request && state != done) begin
      // A new request also restarts a sequence the host abandoned
      state_next = recv_temp1;
    end else begin
      case (state)
        recv_temp1: begin
          if (rx_valid)
            state_next = rx_word.word_ok ? recv_temp2 : error;
        end
        recv_temp2: begin
          if (rx_valid)
            state_next = rx_word.word_ok ? recv_temp3 : error;
        end
        recv_temp3: begin
          if (rx_valid)
            state_next = rx_word.word_ok ? recv_temp4 : error;
        end
        recv_temp4: begin
          if (rx_valid)
            state_next = rx_word.word_ok ? recv_humidity : error;
        end
        recv_humidity: begin
          if (rx_valid)
            state_next = rx_word.word_ok ? done : error;
        end
        done:    state_next = idle;
        idle:    state_next = idle;
        error:   state_next = error; // Held until the host asks again
        default: state_next = idle;
      endcase
    end
  end

  always_comb begin
    load = '0;
    if (rx_valid && rx_word.word_ok) begin
      case (state)
        recv_temp1:    load.temp1    = 1'b1;
        recv_temp2:    load.temp2    = 1'b1;
        recv_temp3:    load.temp3    = 1'b1;
        recv_temp4:    load.temp4    = 1'b1;
        recv_humidity: load.humidity = 1'b1;
        default:       load          = '0;
      endcase
    end
  end

  assign commit       = (state == done);
  assign config_done  = (state == done); // Lasts exactly one cycle
  assign config_error = (state == error);
  assign db_state     = state;

  // Commit only ever follows the load of a good humidity word
  assert property (@(posedge clock) disable iff (reset) commit |-> $past(load.humidity));

endmodule

`default_nettype wire

// File: hdl/cfg_limit_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "climate_cfg_consts.svh"

module cfg_limit_regs import climate_cfg_pkg::*; (
  input  logic            clock,
  input  logic            reset,
  input  rx_word_t        rx_word,
  input  cfg_load_t       load,
  input  logic            commit,
  output climate_limits_t limits
);

  logic [`CFG_DATA_BITS-1:0]  stage [`CFG_WORD_COUNT];
  logic [`CFG_WORD_COUNT-1:0] load_bits;

  // Strobe for temp1 sits in the top bit, humidity in bit 0
  assign load_bits = load;

  always_ff @(posedge clock) begin
    for (int i = 0; i < `CFG_WORD_COUNT; i++) begin
      if (load_bits[`CFG_WORD_COUNT-1-i])
        stage[i] <= rx_word.data;
    end
  end

  // Published values move only when the whole sequence was good
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      limits <= '0;
    end else if (commit) begin
      limits.temp1          <= stage[0];
      limits.temp2          <= stage[1];
      limits.temp3          <= stage[2];
      limits.temp4          <= stage[3];
      limits.humidity_limit <= stage[4];
    end
  end

endmodule

`default_nettype wire

// File: hdl/climate_config_top.sv
`timescale 1ns/1ps
`default_nettype none

module climate_config_top import climate_cfg_pkg::*; (
  input  logic            clock,
  input  logic            reset,
  input  logic            config_request,
  input  logic            serial_in,
  output climate_limits_t limits,
  output logic            config_done,
  output logic            config_error,
  output cfg_state_t      db_state
);

  logic       timer_run;
  logic       sample_tick;
  logic [3:0] bit_index;
  logic       frame_end;
  rx_word_t   rx_word;
  logic       rx_valid;
  cfg_load_t  load;
  logic       commit;

  cfg_bit_timer bit_timer_i (
    .clock       (clock),
    .reset       (reset),
    .run         (timer_run),
    .sample_tick (sample_tick),
    .bit_index   (bit_index),
    .frame_end   (frame_end)
  );

  cfg_serial_rx serial_rx_i (
    .clock       (clock),
    .reset       (reset),
    .serial_in   (serial_in),
    .sample_tick (sample_tick),
    .bit_index   (bit_index),
    .frame_end   (frame_end),
    .timer_run   (timer_run),
    .rx_word     (rx_word),
    .rx_valid    (rx_valid)
  );

  // Words arriving outside a receive state are dropped here
  config_manager_ctrl manager_ctrl_i (
    .clock          (clock),
    .reset          (reset),
    .config_request (config_request),
    .rx_word        (rx_word),
    .rx_valid       (rx_valid),
    .load           (load),
    .commit         (commit),
    .config_done    (config_done),
    .config_error   (config_error),
    .db_state       (db_state)
  );

  cfg_limit_regs limit_regs_i (
    .clock   (clock),
    .reset   (reset),
    .rx_word (rx_word),
    .load    (load),
    .commit  (commit),
    .limits  (limits)
  );

endmodule

`default_nettype wire

// File: verification/climate_config_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "climate_cfg_consts.svh"

module climate_config_tb import climate_cfg_pkg::*;;

  logic            clock;
  logic            reset;
  logic            config_request;
  logic            serial_in;
  climate_limits_t limits;
  logic            config_done;
  logic            config_error;
  cfg_state_t      db_state;

  int          done_pulses;
  int          error_count;
  int          pass_tests;
  int          fail_tests;
  logic [31:0] lfsr_state;

  climate_config_top climate_config_top_i (
    .clock          (clock),
    .reset          (reset),
    .config_request (config_request),
    .serial_in      (serial_in),
    .limits         (limits),
    .config_done    (config_done),
    .config_error   (config_error),
    .db_state       (db_state)
  );

  initial clock = 1'b0;
  always #50 clock = ~clock;

  // Counts cycles with config_done high, sampled away from the rising edge
  always @(negedge clock) begin
    if (reset)
      done_pulses = 0;
    else if (config_done)
      done_pulses = done_pulses + 1;
  end

  // Taps 32, 22, 2 and 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic random_bits(input int n, output int val);
    val = 0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      val = {val[30:0], lfsr_state[0]};
    end
  endtask

  task automatic check_value(input logic [39:0] actual, input logic [39:0] expected,
                             input string what);
    if (actual !== expected) begin
      $display("[ERROR] %0d ns: %s is %h, expected %h", $time, what, actual, expected);
      error_count++;
    end
  endtask

  task automatic report_test(input string name, input int errors_before);
    if (error_count == errors_before) begin
      pass_tests++;
      $display("%s: PASS", name);
    end else begin
      fail_tests++;
      $display("%s: FAIL", name);
    end
  endtask

  // Every wait ends 5 ns after a rising edge, where inputs are driven
  task automatic idle_cycles(input int n);
    repeat (n) @(posedge clock);
    #5;
  endtask

  task automatic hold_bit(input logic b);
    serial_in = b;
    idle_cycles(`CFG_BIT_CYCLES);
  endtask

  task automatic send_request();
    config_request = 1'b1;
    idle_cycles(1);
    config_request = 1'b0;
  endtask

  task automatic send_frame(input logic [7:0] data, input logic bad_parity);
    logic [`CFG_DATA_BITS+2:0] bits;
    bits = {1'b1, (^data) ^ bad_parity, data, 1'b0}; // Stop, parity, data, start
    for (int i = 0; i < `CFG_DATA_BITS + 3; i++)
      hold_bit(bits[i]);
  endtask

  task automatic wait_for_done(input int start_count, output logic seen);
    int waited;
    waited = 0;
    seen   = 1'b0;
    while (!seen && waited < 20 * `CFG_BIT_CYCLES) begin
      if (done_pulses != start_count) begin
        seen = 1'b1;
      end else begin
        idle_cycles(1);
        waited++;
      end
    end
  endtask

  initial begin
    int          fd;
    int          fields;
    int          line_no;
    int          start_done;
    int          gap;
    int          f_req;
    int          f_mask;
    int          f_count;
    int          f_done;
    int          f_err;
    int          errors_before;
    logic [7:0]  d0, d1, d2, d3, d4;
    logic [7:0]  e0, e1, e2, e3, e4;
    logic [7:0]  data_bytes [`CFG_WORD_COUNT];
    logic        seen;
    logic        aborted;
    string       text;
    string       name;

    reset          = 1'b1;
    config_request = 1'b0;
    serial_in      = 1'b1; // Line idles high
    lfsr_state     = 32'h94fd;
    error_count    = 0;
    pass_tests     = 0;
    fail_tests     = 0;
    line_no        = 0;
    aborted        = 1'b0;

    repeat (3) @(posedge clock);
    #5;
    reset = 1'b0;

    errors_before = error_count;
    check_value(limits, 40'h0, "limits after reset");
    check_value(40'(config_error), 40'h0, "config_error after reset");
    check_value(40'(db_state), 40'(idle), "db_state after reset");
    report_test("reset values", errors_before);

    fd = $fopen("verification/climate_config_patterns.txt", "r");
    if (fd == 0) begin
      $display("Could not open the pattern file verification/climate_config_patterns.txt");
      aborted = 1'b1;
    end

    while (!aborted && $fgets(text, fd) != 0) begin
      line_no++;
      if (text.len() < 2 || text.getc(0) == "#")
        continue;
      fields = $sscanf(text, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                       f_req, d0, d1, d2, d3, d4, f_mask, f_count, f_done, f_err,
                       e0, e1, e2, e3, e4);
      if (fields != 15) begin
        $display("Pattern line %0d has %0d fields instead of 15", line_no, fields);
        fail_tests++;
        continue;
      end
      data_bytes[0] = d0;
      data_bytes[1] = d1;
      data_bytes[2] = d2;
      data_bytes[3] = d3;
      data_bytes[4] = d4;
      errors_before = error_count;
      start_done    = done_pulses;

      if (f_req != 0)
        send_request();
      for (int k = 0; k < f_count && k < `CFG_WORD_COUNT; k++) begin
        random_bits(2, gap);
        idle_cycles((gap + 1) * `CFG_BIT_CYCLES); // One to four idle bits
        send_frame(data_bytes[k], f_mask[k]);
      end

      if (f_done != 0) begin
        wait_for_done(start_done, seen);
        if (!seen) begin
          $display("Timed out waiting for config_done after pattern line %0d", line_no);
          fail_tests++;
          aborted = 1'b1;
        end
      end

      if (!aborted) begin
        idle_cycles(2 * `CFG_BIT_CYCLES); // Lets a late pulse show up in the count
        check_value(40'(done_pulses - start_done), 40'(f_done), "config_done pulses");
        check_value(40'(config_error), 40'(f_err), "config_error");
        check_value(limits, {e0, e1, e2, e3, e4}, "limits");
        name = $sformatf("pattern line %0d", line_no);
        report_test(name, errors_before);
      end
    end
    if (fd != 0)
      $fclose(fd);

    $display("Tests run: %0d, passed: %0d, failed: %0d, check errors: %0d",
             pass_tests + fail_tests, pass_tests, fail_tests, error_count);
    if (!aborted && fail_tests == 0 && error_count == 0 && pass_tests > 1) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verification/climate_config_patterns.txt
# req d0 d1 d2 d3 d4 bad_parity_mask frames done error lim_t1 lim_t2 lim_t3 lim_t4 lim_hum
# All fields hex; mask bit 0 flips the parity bit of the first frame sent
1 15 19 1e 23 3c 00 5 1 0 15 19 1e 23 3c
1 10 12 14 16 40 00 5 1 0 10 12 14 16 40
1 aa bb cc dd ee 04 5 0 1 10 12 14 16 40
1 0f 11 13 17 38 00 5 1 0 0f 11 13 17 38
0 55 66 77 88 99 00 5 0 0 0f 11 13 17 38
1 12 16 1a 1f 41 01 5 0 1 0f 11 13 17 38
0 01 02 03 04 05 00 3 0 1 0f 11 13 17 38
1 14 18 1c 20 45 00 5 1 0 14 18 1c 20 45
1 21 22 23 24 25 00 3 0 0 14 18 1c 20 45
1 0c 10 14 18 32 00 5 1 0 0c 10 14 18 32
1 ff 00 80 7f 01 10 5 0 1 0c 10 14 18 32
1 ff 00 80 7f 01 00 5 1 0 ff 00 80 7f 01
1 33 34 35 36 37 00 1 0 0 ff 00 80 7f 01
1 08 0a 0d 11 2d 00 5 1 0 08 0a 0d 11 2d
1 5a a5 3c c3 69 1f 5 0 1 08 0a 0d 11 2d
1 5a a5 3c c3 69 00 5 1 0 5a a5 3c c3 69
1 13 17 1b 1e 46 08 5 0 1 5a a5 3c c3 69
0 99 99 99 99 99 00 2 0 1 5a a5 3c c3 69
1 13 17 1b 1e 46 00 5 1 0 13 17 1b 1e 46
1 01 02 04 08 10 02 4 0 1 13 17 1b 1e 46
1 18 1a 1c 1e 3a 00 4 0 0 13 17 1b 1e 46
1 18 1a 1c 1e 3a 00 5 1 0 18 1a 1c 1e 3a
0 00 00 00 00 00 00 5 0 0 18 1a 1c 1e 3a

// File: all.f
+incdir+include
hdl/climate_cfg_pkg.sv
hdl/cfg_bit_timer.sv
hdl/cfg_serial_rx.sv
hdl/config_manager_ctrl.sv
hdl/cfg_limit_regs.sv
hdl/climate_config_top.sv
verification/climate_config_tb.sv

// File: run.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --timescale 1ns/1ps \
  --top-module climate_config_tb \
  -f all.f \
  -o climate_config_sim

./obj_dir/climate_config_sim > sim.log 2>&1
cat sim.log

if grep -qx "Test passed" sim.log; then
  echo "Simulation PASSED"
  exit 0
else
  echo "Simulation FAILED"
  exit 1
fi
